// File: hdl/memWbIf.sv
// Memory to writeback stage bundle
// Carries one instruction's memory-stage results from the top level
// into the datapath and exception halves of the writeback stage
`timescale 1ns/100ps

interface memWbIf import wbPkg::*; ();

    word_t      aluOut;         // alu result, also the load address
    word_t      dmOut;          // raw word read from the data memory
    word_t      operandB;
    word_t      pc;             // pc of the instruction itself
    wbSel_t     wbSel;
    regAddr_t   dst;
    loadType_t  loadType;
    logic       regWr;          // instruction writes a register
    excCode_t   excCode;
    logic       inDelaySlot;    // instruction sits behind a branch

    // top level fills every field from its plain ports
    modport src (
        output aluOut, dmOut, operandB, pc, wbSel, dst, loadType, regWr,
        output excCode, inDelaySlot
    );

    modport data (
        input aluOut, dmOut, operandB, pc, wbSel, dst, loadType, regWr
    );

    // exception half only needs enough to build the report
    modport exc (
        input pc, excCode, inDelaySlot
    );

endinterface

// File: hdl/regCommit.sv
// Register commit and register file
// Gates the register write with the exception and data-cache stall
// state, and holds the 32-entry register file with one read port
`timescale 1ns/100ps

module regCommit import wbPkg::*; (
    input  logic        clk,
    input  logic        arstN,
    input  logic        disWr,          // data-cache stall level
    input  word_t       result,
    input  regAddr_t    dst,
    input  logic        regWr,
    input  logic        excValid,
    input  regAddr_t    rdAddr,
    output word_t       rdData,
    output logic        regWe
);

    localparam int RegCount = 2 ** $bits(regAddr_t);

    word_t regFile [RegCount];

    // ********************************************************************
    // write enable
    // ********************************************************************
    // an excepting instruction must not change architectural state, and a
    // stalled one rewrites the same value once the stall drops
    assign regWe = regWr && !excValid && !disWr && (dst != '0);

    // ********************************************************************
    // register file
    // ********************************************************************
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < RegCount; i++) begin
                regFile[i] <= '0;
            end
        end else if (regWe) begin
            regFile[dst] <= result;
        end
    end

    // no bypass, a write shows up after its edge
    assign rdData = (rdAddr == '0) ? '0 : regFile[rdAddr];

    // a committed write must carry a known destination and value
    assert property (@(posedge clk) disable iff (!arstN)
        regWe |-> !$isunknown({dst, result}))
        else $error("register write with an unknown destination or value");

endmodule

// File: hdl/wbDatapath.sv
// Writeback datapath
// Registers the data fields of the instruction, extends loaded bytes
// and halfwords, and selects the value written back to the register file
`timescale 1ns/100ps

module wbDatapath import wbPkg::*; (
    input  logic        clk,
    input  logic        arstN,
    input  logic        wr,             // stage write enable
    input  logic        flush,          // load a bubble, wins over wr
    memWbIf.data        mw,
    output word_t       result,
    output regAddr_t    dst,
    output logic        regWr
);

    word_t      aluOutQ;
    word_t      dmOutQ;
    word_t      operandBQ;
    word_t      pcQ;
    wbSel_t     wbSelQ;
    loadType_t  loadTypeQ;
    regAddr_t   dstQ;
    logic       regWrQ;

    logic [7:0]  loadByte;
    logic [15:0] loadHalf;
    word_t       loadExt;

    // ********************************************************************
    // stage register
    // ********************************************************************
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            regWrQ    <= 1'b0;
            wbSelQ    <= selAlu;
            loadTypeQ <= ldNone;
            dstQ      <= '0;
        end else if (flush) begin
            regWrQ    <= 1'b0;                  // bubble never writes
            wbSelQ    <= selAlu;
            loadTypeQ <= ldNone;
            dstQ      <= '0;
        end else if (wr) begin
            regWrQ    <= mw.regWr;
            wbSelQ    <= mw.wbSel;
            loadTypeQ <= mw.loadType;
            dstQ      <= mw.dst;
        end
    end

    always_ff @(posedge clk) begin
        if (wr && !flush) begin
            aluOutQ   <= mw.aluOut;
            dmOutQ    <= mw.dmOut;
            operandBQ <= mw.operandB;
            pcQ       <= mw.pc;
        end
    end

    // ********************************************************************
    // load extension, little-endian lanes picked by the address
    // ********************************************************************
    always_comb begin
        unique case (aluOutQ[1:0])
            2'd0:    loadByte = dmOutQ[7:0];
            2'd1:    loadByte = dmOutQ[15:8];
            2'd2:    loadByte = dmOutQ[23:16];
            default: loadByte = dmOutQ[31:24];
        endcase
        loadHalf = aluOutQ[1] ? dmOutQ[31:16] : dmOutQ[15:0];   // bit 0 is ignored
    end

    always_comb begin
        case (loadTypeQ)
            ldByteSigned:   loadExt = {{24{loadByte[7]}}, loadByte};
            ldByteUnsigned: loadExt = {24'd0, loadByte};
            ldHalfSigned:   loadExt = {{16{loadHalf[15]}}, loadHalf};
            ldHalfUnsigned: loadExt = {16'd0, loadHalf};
            default:        loadExt = dmOutQ;   // whole word
        endcase
    end

    // ********************************************************************
    // result select
    // ********************************************************************
    always_comb begin
        unique case (wbSelQ)
            selLink:     result = pcQ + 32'd8;  // skip the delay slot
            selAlu:      result = aluOutQ;
            selOperandB: result = operandBQ;
            default:     result = loadExt;
        endcase
    end

    assign dst   = dstQ;
    assign regWr = regWrQ;

    // the load path must know how wide the access was
    assert property (@(posedge clk) disable iff (!arstN)
        (wbSelQ == selLoad) |-> (loadTypeQ != ldNone))
        else $error("load result selected without a load type");

endmodule

// File: hdl/wbExcept.sv
// Writeback exception report
// Registers the exception fields of the instruction and reports whether
// it commits an exception, with the return address fixed for delay slots
`timescale 1ns/100ps

`include "writeBack_defs.svh"

module wbExcept import wbPkg::*; (
    input  logic        clk,
    input  logic        arstN,
    input  logic        wr,
    input  logic        flush,
    memWbIf.exc         mw,
    output logic        excValid,
    output excCode_t    excCode,
    output word_t       epc             // exception return address
);

    word_t      pcQ;
    excCode_t   excCodeQ;
    logic       inDelaySlotQ;

    // ********************************************************************
    // stage register
    // ********************************************************************
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            excCodeQ     <= `EXC_NONE;
            inDelaySlotQ <= 1'b0;
        end else if (flush) begin
            excCodeQ     <= `EXC_NONE;          // a bubble raises nothing
            inDelaySlotQ <= 1'b0;
        end else if (wr) begin
            excCodeQ     <= mw.excCode;
            inDelaySlotQ <= mw.inDelaySlot;
        end
    end

    always_ff @(posedge clk) begin
        if (wr && !flush) begin
            pcQ <= mw.pc;
        end
    end

    // ********************************************************************
    // exception report
    // ********************************************************************
    assign excValid = (excCodeQ != `EXC_NONE);
    assign excCode  = excCodeQ;

    // restart at the branch so the slot instruction runs again behind it
    assign epc = inDelaySlotQ ? pcQ - 32'd4 : pcQ;

    // only the causes this pipeline can raise may reach the report
    assert property (@(posedge clk) disable iff (!arstN)
        excValid |-> (excCodeQ inside {`EXC_ADEL, `EXC_SYS, `EXC_BP, `EXC_RI, `EXC_OV}))
        else $error("unknown exception code reported");

endmodule

// File: hdl/wbPkg.sv
// Writeback stage shared types
// Word and register number vectors, result select and load type enums,
// and the exception code vector used across the stage
package wbPkg;

`include "writeBack_defs.svh"

    // ********************************************************************
    // vector types
    // ********************************************************************
    typedef logic [`WB_DATA_W-1:0]          word_t;     // data or address word
    typedef logic [$clog2(`WB_REG_NUM)-1:0] regAddr_t;  // register number
    typedef logic [4:0]                     excCode_t;  // zero means none

    // ********************************************************************
    // writeback result source
    // ********************************************************************
    typedef enum logic [1:0] {
        selLink     = `WB_SEL_LINK,     // return address of a link jump
        selAlu      = `WB_SEL_ALU,
        selOperandB = `WB_SEL_OPB,      // mtc0 style moves pass operand b
        selLoad     = `WB_SEL_LOAD
    } wbSel_t;

    // ********************************************************************
    // load width and extension
    // ********************************************************************
    typedef enum logic [2:0] {
        ldNone         = 3'd0,          // not a load
        ldWord         = 3'd1,
        ldByteSigned   = 3'd2,          // lb
        ldByteUnsigned = 3'd3,          // lbu
        ldHalfSigned   = 3'd4,          // lh
        ldHalfUnsigned = 3'd5           // lhu
    } loadType_t;

endpackage

// File: hdl/wbTop.sv
// Writeback stage top level
// Bundles the memory-stage results into the stage interface and connects
// the datapath, exception and register commit blocks
`timescale 1ns/100ps

module wbTop import wbPkg::*; (
    input  logic        clk,
    input  logic        arstN,
    input  logic        wbWr,
    input  logic        wbFlush,
    input  logic        wbDisWr,
    input  word_t       memAluOut,
    input  word_t       memDmOut,
    input  word_t       memOperandB,
    input  word_t       memPc,
    input  wbSel_t      memWbSel,
    input  regAddr_t    memDst,
    input  loadType_t   memLoadType,
    input  logic        memRegWr,
    input  excCode_t    memExcCode,
    input  logic        memInDelaySlot,
    input  regAddr_t    rdAddr,
    output word_t       wbResult,
    output regAddr_t    wbDst,
    output logic        wbRegWe,
    output logic        excValid,
    output excCode_t    excCode,
    output word_t       excEpc,
    output word_t       rdData
);

    logic wbRegWr;                      // register write before gating

    memWbIf mwBus ();

    // ********************************************************************
    // memory stage fields into the bundle
    // ********************************************************************
    assign mwBus.aluOut      = memAluOut;
    assign mwBus.dmOut       = memDmOut;
    assign mwBus.operandB    = memOperandB;
    assign mwBus.pc          = memPc;
    assign mwBus.wbSel       = memWbSel;
    assign mwBus.dst         = memDst;
    assign mwBus.loadType    = memLoadType;
    assign mwBus.regWr       = memRegWr;
    assign mwBus.excCode     = memExcCode;
    assign mwBus.inDelaySlot = memInDelaySlot;

    // ********************************************************************
    // stage blocks
    // ********************************************************************
    wbDatapath i_wbDatapath (
        .clk      (clk),
        .arstN    (arstN),
        .wr       (wbWr),
        .flush    (wbFlush),
        .mw       (mwBus.data),
        .result   (wbResult),
        .dst      (wbDst),
        .regWr    (wbRegWr)
    );

    wbExcept i_wbExcept (
        .clk      (clk),
        .arstN    (arstN),
        .wr       (wbWr),
        .flush    (wbFlush),
        .mw       (mwBus.exc),
        .excValid (excValid),
        .excCode  (excCode),
        .epc      (excEpc)
    );

    regCommit i_regCommit (
        .clk      (clk),
        .arstN    (arstN),
        .disWr    (wbDisWr),
        .result   (wbResult),
        .dst      (wbDst),
        .regWr    (wbRegWr),
        .excValid (excValid),
        .rdAddr   (rdAddr),
        .rdData   (rdData),
        .regWe    (wbRegWe)
    );

endmodule

// File: include/writeBack_defs.svh
// Writeback stage architectural constants
// Widths, register count, result select codes and exception codes
// are all fixed by the MIPS-style integer instruction set
`ifndef WRITEBACK_DEFS_SVH
`define WRITEBACK_DEFS_SVH

// ********************************************************************
// datapath dimensions
// ********************************************************************
`define WB_DATA_W       32      // data and address word width
`define WB_REG_NUM      32      // general purpose registers, r0 hardwired

// ********************************************************************
// writeback result select codes
// ********************************************************************
`define WB_SEL_LINK     2'd0    // pc plus 8 for jal and jalr
`define WB_SEL_ALU      2'd1    // arithmetic or logic result
`define WB_SEL_OPB      2'd2    // move operand straight through
`define WB_SEL_LOAD     2'd3    // extended data from the data memory

// ********************************************************************
// exception codes, cause register encoding
// ********************************************************************
`define EXC_NONE        5'h00   // no exception pending
`define EXC_ADEL        5'h04   // address error on load or fetch
`define EXC_SYS         5'h08   // syscall
`define EXC_BP          5'h09   // break
`define EXC_RI          5'h0a   // reserved instruction
`define EXC_OV          5'h0c   // arithmetic overflow

`endif

// File: runSim.sh
#!/bin/sh
# Build the writeback stage testbench with Verilator and run it.
# The exit status is the simulator's, nonzero when the testbench fails.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f writeBack.f --top-module wbTop_tb -o wbTop_sim &&
./obj_dir/wbTop_sim || exit 1

// File: test/tbClock.sv
// Testbench clock source
// Free-running clock with a 10 ns period, starting low
`timescale 1ns/100ps

module tbClock (
    output logic clk
);

    localparam int HalfPeriod = 5;      // in ns, gives the 10 ns period

    initial begin
        clk = 1'b0;
        forever #HalfPeriod clk = ~clk;
    end

endmodule

// File: test/wbTop_tb.sv
// Writeback stage testbench
// Reads stimulus vectors with expected results from the test data file,
// drives them into the writeback stage and checks every output, then
// sweeps random registers against a model of the register file
`timescale 1ns/100ps

`include "writeBack_defs.svh"

module wbTop_tb import wbPkg::*; ();

    // ********************************************************************
    // test data layout
    // ********************************************************************
    localparam int MaxVectors  = 64;
    localparam int NumFields   = 19;
    localparam int SweepReads  = 16;

    localparam int idxAluOut      = 0;
    localparam int idxDmOut       = 1;
    localparam int idxOperandB    = 2;
    localparam int idxPc          = 3;
    localparam int idxWbSel       = 4;
    localparam int idxDst         = 5;
    localparam int idxLoadType    = 6;
    localparam int idxRegWr       = 7;
    localparam int idxExcCode     = 8;
    localparam int idxDelaySlot   = 9;
    localparam int idxWr          = 10;
    localparam int idxFlush       = 11;
    localparam int idxDisWr       = 12;
    localparam int idxRdAddr      = 13;
    localparam int idxExpResult   = 14;
    localparam int idxExpRegWe    = 15;
    localparam int idxExpExcValid = 16;
    localparam int idxExpEpc      = 17;
    localparam int idxExpRdData   = 18;

    logic        clk;
    logic        arstN;
    logic        wbWr;
    logic        wbFlush;
    logic        wbDisWr;
    word_t       memAluOut;
    word_t       memDmOut;
    word_t       memOperandB;
    word_t       memPc;
    wbSel_t      memWbSel;
    regAddr_t    memDst;
    loadType_t   memLoadType;
    logic        memRegWr;
    excCode_t    memExcCode;
    logic        memInDelaySlot;
    regAddr_t    rdAddr;
    word_t       wbResult;
    regAddr_t    wbDst;
    logic        wbRegWe;
    logic        excValid;
    excCode_t    excCode;
    word_t       excEpc;
    word_t       rdData;

    string       vecNames [MaxVectors];
    logic [31:0] vecData [MaxVectors][NumFields];
    logic [31:0] fld [NumFields];
    int          vecCount = 0;
    int          cycleCount = 0;
    int          cycleLimit = 0;        // zero until the vectors are counted
    int          seed = 48421;
    int          fd;
    int          items;
    string       line;
    string       name;
    logic [31:0] rnd;
    regAddr_t    sweepAddr;

    // model of the staged instruction and the architectural registers
    word_t       shadow [`WB_REG_NUM];
    logic        stRegWr;
    excCode_t    stExcCode;
    regAddr_t    stDst;
    word_t       stResult;

    tbClock i_tbClock (
        .clk (clk)
    );

    wbTop i_wbTop (
        .clk            (clk),
        .arstN          (arstN),
        .wbWr           (wbWr),
        .wbFlush        (wbFlush),
        .wbDisWr        (wbDisWr),
        .memAluOut      (memAluOut),
        .memDmOut       (memDmOut),
        .memOperandB    (memOperandB),
        .memPc          (memPc),
        .memWbSel       (memWbSel),
        .memDst         (memDst),
        .memLoadType    (memLoadType),
        .memRegWr       (memRegWr),
        .memExcCode     (memExcCode),
        .memInDelaySlot (memInDelaySlot),
        .rdAddr         (rdAddr),
        .wbResult       (wbResult),
        .wbDst          (wbDst),
        .wbRegWe        (wbRegWe),
        .excValid       (excValid),
        .excCode        (excCode),
        .excEpc         (excEpc),
        .rdData         (rdData)
    );

    // ********************************************************************
    // helpers
    // ********************************************************************
    task automatic checkValue(input string testName, input string label,
                              input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("error in %s: %s expected %h, actual %h", testName, label, expected, actual);
            $display("TB FAILED");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic stopWithFailure(input string reason);
        $display("%s", reason);
        $display("TB FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic driveVector(input int n);
        memAluOut      = vecData[n][idxAluOut];
        memDmOut       = vecData[n][idxDmOut];
        memOperandB    = vecData[n][idxOperandB];
        memPc          = vecData[n][idxPc];
        memWbSel       = wbSel_t'(vecData[n][idxWbSel][1:0]);
        memDst         = vecData[n][idxDst][4:0];
        memLoadType    = loadType_t'(vecData[n][idxLoadType][2:0]);
        memRegWr       = vecData[n][idxRegWr][0];
        memExcCode     = vecData[n][idxExcCode][4:0];
        memInDelaySlot = vecData[n][idxDelaySlot][0];
        wbWr           = vecData[n][idxWr][0];
        wbFlush        = vecData[n][idxFlush][0];
        wbDisWr        = vecData[n][idxDisWr][0];
        rdAddr         = vecData[n][idxRdAddr][4:0];
    endtask

    // the staged instruction is written at the coming edge unless stalled
    task automatic commitWrite(input logic disWr);
        if (stRegWr && stExcCode == `EXC_NONE && stDst != '0 && !disWr) begin
            shadow[stDst] = stResult;
        end
    endtask

    task automatic advanceStage(input logic flush, input logic wr, input int n);
        if (flush) begin
            stRegWr   = 1'b0;           // bubble
            stExcCode = `EXC_NONE;
            stDst     = '0;
        end else if (wr) begin
            stRegWr   = vecData[n][idxRegWr][0];
            stExcCode = vecData[n][idxExcCode][4:0];
            stDst     = vecData[n][idxDst][4:0];
            stResult  = vecData[n][idxExpResult];
        end
    endtask

    task automatic checkVector(input int n);
        checkValue(vecNames[n], "wbResult", vecData[n][idxExpResult], wbResult);
        checkValue(vecNames[n], "wbDst", {27'b0, stDst}, {27'b0, wbDst});
        checkValue(vecNames[n], "wbRegWe", vecData[n][idxExpRegWe], {31'b0, wbRegWe});
        checkValue(vecNames[n], "excValid", vecData[n][idxExpExcValid], {31'b0, excValid});
        checkValue(vecNames[n], "excCode", {27'b0, stExcCode}, {27'b0, excCode});
        checkValue(vecNames[n], "excEpc", vecData[n][idxExpEpc], excEpc);
        checkValue(vecNames[n], "rdData", vecData[n][idxExpRdData], rdData);
    endtask

    // ********************************************************************
    // cycle limit
    // ********************************************************************
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit != 0 && cycleCount >= cycleLimit) begin
            $display("timeout after %0d clock cycles, the run did not finish", cycleCount);
            $display("TB FAILED");
            $fatal(1, "cycle limit reached");
        end
    end

    // ********************************************************************
    // main sequence
    // ********************************************************************
    initial begin
        arstN = 1'b0;
        wbWr = 1'b0;
        wbFlush = 1'b0;
        wbDisWr = 1'b0;
        memAluOut = '0;
        memDmOut = '0;
        memOperandB = '0;
        memPc = '0;
        memWbSel = selAlu;
        memDst = '0;
        memLoadType = ldNone;
        memRegWr = 1'b0;
        memExcCode = '0;
        memInDelaySlot = 1'b0;
        rdAddr = '0;
        stRegWr = 1'b0;
        stExcCode = `EXC_NONE;
        stDst = '0;
        stResult = '0;
        for (int r = 0; r < `WB_REG_NUM; r++) begin
            shadow[r] = '0;
        end

        fd = $fopen("test/wbTop_testdata.txt", "r");
        if (fd == 0) begin
            stopWithFailure("could not open the test data file");
        end
        while (!$feof(fd)) begin
            line = "";
            items = $fgets(line, fd);
            if (items > 0 && line.len() > 1 && line[0] != "#") begin
                items = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                name, fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6],
                                fld[7], fld[8], fld[9], fld[10], fld[11], fld[12], fld[13],
                                fld[14], fld[15], fld[16], fld[17], fld[18]);
                if (items != NumFields + 1 || vecCount >= MaxVectors) begin
                    stopWithFailure("malformed line or too many lines in the test data file");
                end
                vecNames[vecCount] = name;
                for (int k = 0; k < NumFields; k++) begin
                    vecData[vecCount][k] = fld[k];
                end
                vecCount++;
            end
        end
        $fclose(fd);
        if (vecCount == 0) begin
            stopWithFailure("the test data file holds no vectors");
        end
        cycleLimit = 4 * vecCount + 50;

        repeat (2) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
        checkValue("reset", "wbRegWe", 32'd0, {31'b0, wbRegWe});    // stage holds a bubble
        checkValue("reset", "excValid", 32'd0, {31'b0, excValid});
        checkValue("reset", "rdData", 32'd0, rdData);

        for (int n = 0; n < vecCount; n++) begin
            @(negedge clk);
            driveVector(n);
            commitWrite(vecData[n][idxDisWr][0]);
            advanceStage(vecData[n][idxFlush][0], vecData[n][idxWr][0], n);
            @(posedge clk);
            #1;
            checkVector(n);
        end

        // random read-back of the whole file with the stage flushed
        for (int i = 0; i < SweepReads; i++) begin
            @(negedge clk);
            rnd = $random(seed);
            sweepAddr = rnd[4:0];
            rdAddr = sweepAddr;
            wbWr = 1'b0;
            wbFlush = 1'b1;
            wbDisWr = 1'b0;
            commitWrite(1'b0);
            advanceStage(1'b1, 1'b0, 0);
            @(posedge clk);
            #1;
            checkValue($sformatf("sweep_r%0d", sweepAddr), "rdData", shadow[sweepAddr], rdData);
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

// File: test/wbTop_testdata.txt
# name aluOut dmOut operandB pc wbSel dst loadType regWr excCode inDelaySlot wbWr wbFlush wbDisWr rdAddr
# then expected wbResult wbRegWe excValid excEpc rdData, every field in hex
alu_r5     12345678 00000000 00000000 00400000 1 05 0 1 00 0 1 0 0 05 12345678 1 0 00400000 00000000
opb_r6     00000000 00000000 cafef00d 00400004 2 06 0 1 00 0 1 0 0 05 cafef00d 1 0 00400004 12345678
link_r31   00000000 00000000 00000000 00400008 0 1f 0 1 00 0 1 0 0 06 00400010 1 0 00400008 cafef00d
alu_r7     00000011 00000000 00000000 0040000c 1 07 0 1 00 0 1 0 0 1f 00000011 1 0 0040000c 00400010
lw_off0    00001000 80ff7f01 00000000 00400010 3 08 1 1 00 0 1 0 0 07 80ff7f01 1 0 00400010 00000011
lb_off0    00001000 80ff7f01 00000000 00400014 3 08 2 1 00 0 1 0 0 08 00000001 1 0 00400014 80ff7f01
lb_off1    00001001 80ff7f01 00000000 00400018 3 08 2 1 00 0 1 0 0 08 0000007f 1 0 00400018 00000001
lb_off2    00001002 80ff7f01 00000000 0040001c 3 08 2 1 00 0 1 0 0 08 ffffffff 1 0 0040001c 0000007f
lb_off3    00001003 80ff7f01 00000000 00400020 3 08 2 1 00 0 1 0 0 08 ffffff80 1 0 00400020 ffffffff
lbu_off2   00001002 80ff7f01 00000000 00400024 3 08 3 1 00 0 1 0 0 08 000000ff 1 0 00400024 ffffff80
lbu_off3   00001003 80ff7f01 00000000 00400028 3 08 3 1 00 0 1 0 0 08 00000080 1 0 00400028 000000ff
lbu_off0   00001000 80ff7f01 00000000 0040002c 3 08 3 1 00 0 1 0 0 08 00000001 1 0 0040002c 00000080
lbu_off1   00001001 80ff7f01 00000000 00400030 3 08 3 1 00 0 1 0 0 08 0000007f 1 0 00400030 00000001
lh_off0    00001000 80ff7f01 00000000 00400034 3 08 4 1 00 0 1 0 0 08 00007f01 1 0 00400034 0000007f
lh_off2    00001002 80ff7f01 00000000 00400038 3 08 4 1 00 0 1 0 0 08 ffff80ff 1 0 00400038 00007f01
lhu_off0   00001000 80ff7f01 00000000 0040003c 3 08 5 1 00 0 1 0 0 08 00007f01 1 0 0040003c ffff80ff
lhu_off2   00001002 80ff7f01 00000000 00400040 3 08 5 1 00 0 1 0 0 08 000080ff 1 0 00400040 00007f01
exc_ov     deadbeef 00000000 00000000 00400044 1 05 0 1 0c 0 1 0 0 08 deadbeef 0 1 00400044 000080ff
exc_slot   0badc0de 00000000 00000000 00400048 1 05 0 1 0a 1 1 0 0 05 0badc0de 0 1 00400044 12345678
after_exc  00000055 00000000 00000000 0040004c 1 09 0 1 00 0 1 0 0 05 00000055 1 0 0040004c 12345678
stall_on   00000000 00000000 00000000 00000000 0 00 0 0 00 0 0 0 1 09 00000055 0 0 0040004c 00000000
stall_keep 00000000 00000000 00000000 00000000 0 00 0 0 00 0 0 0 1 09 00000055 0 0 0040004c 00000000
stall_off  00000000 00000000 00000000 00000000 0 00 0 0 00 0 0 0 0 09 00000055 1 0 0040004c 00000055
hold_wr0   ffffffff ffffffff ffffffff ffffffff 1 1f 0 1 00 0 0 0 0 09 00000055 1 0 0040004c 00000055
flush      ffffffff ffffffff ffffffff ffffffff 1 1f 0 1 04 1 1 1 0 09 00000055 0 0 0040004c 00000055
r0_write   77777777 00000000 00000000 00400054 1 00 0 1 00 0 1 0 0 00 77777777 0 0 00400054 00000000
no_regwr   00000001 00000000 00000000 00400058 1 0b 0 0 00 0 1 0 0 00 00000001 0 0 00400058 00000000
unwritten  00000000 00000000 00000000 00000000 1 00 0 0 00 0 0 1 0 0c 00000001 0 0 00400058 00000000

// File: writeBack.f
+incdir+include
hdl/wbPkg.sv
hdl/memWbIf.sv
hdl/wbDatapath.sv
hdl/wbExcept.sv
hdl/regCommit.sv
hdl/wbTop.sv
test/tbClock.sv
test/wbTop_tb.sv
